// File: common/cpu_pkg.sv
//////////////////////////////////////////////////
// cpu_pkg: shared types, opcodes and constants
// for the boot-loaded four-stage integer core
//////////////////////////////////////////////////
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // host bus operations
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11
    } host_op_e;

    // instruction opcodes, bits 31..24
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        ADD  = 8'h10,
        SUB  = 8'h11,
        AND  = 8'h12,
        OR   = 8'h13,
        XOR  = 8'h14,
        ADDI = 8'h18,
        LD   = 8'h81,
        ST   = 8'h83
    } opcode_e;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        REQ_DM,
        LOAD_DM,
        REQ_IM,
        LOAD_IM,
        RUN,
        WRT_HOST
    } ctrl_state_e;

    //////////////////////////////////////////////////
    // bus and pipeline bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        host_op_e    op;
        logic [31:0] addr;
        word_t       data;
    } host_req_t;

    typedef struct packed {
        logic        en;
        logic [15:0] addr;    // word index
        word_t       data;
    } mem_wr_t;

    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [15:0] addr;    // byte address
        word_t       data;
    } dm_access_t;

    typedef struct packed {
        opcode_e  op;
        word_t    a;          // rs value
        word_t    b;          // rt, or rd for stores
        word_t    imm;        // sign-extended
        reg_idx_t dst;
    } issue_t;

    localparam logic [15:0] HOST_WINDOW  = 16'h9000;
    localparam logic [31:0] DM_HOST_BASE = 32'h0000_1000;
    localparam logic [31:0] IM_HOST_BASE = 32'h8000_0000;

    // instruction field positions
    localparam int OPC_LSB = 24;
    localparam int RD_LSB  = 20;
    localparam int RS_LSB  = 16;
    localparam int RT_LSB  = 12;
    localparam int IMM_W   = 16;

endpackage

// File: core/decode_stage.sv
//////////////////////////////////////////////////
// decode_stage: pc, fetch/decode register, decoder,
// register file and RAW hazard detection
//////////////////////////////////////////////////
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run_en,
    input  word_t       instr,
    output logic [15:0] fetch_addr,
    input  logic        wb_en,
    input  reg_idx_t    wb_idx,
    input  word_t       wb_data,
    input  reg_idx_t    ex_dst,
    input  logic        ex_wr,
    output issue_t      issue
);

    logic [15:0] pc, pc_d;
    logic        fd_valid;    // instr holds a fetched instruction
    opcode_e     op;
    logic        legal, use_rs, use_src2, stall;
    reg_idx_t    src1, src2;
    word_t       rs_val, src2_val;
    word_t       regs [16];

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    assign op = opcode_e'(instr[OPC_LSB +: 8]);

    always_comb begin
        legal    = 1'b1;
        use_rs   = 1'b1;
        use_src2 = 1'b0;
        case (op)
            ADD, SUB, AND, OR, XOR: use_src2 = 1'b1;
            ADDI, LD:               use_src2 = 1'b0;
            ST:                     use_src2 = 1'b1;    // rd is store data
            default: begin
                legal  = 1'b0;                          // nop and unknown
                use_rs = 1'b0;
            end
        endcase
    end

    assign src1 = instr[RS_LSB +: 4];
    assign src2 = (op == ST) ? instr[RD_LSB +: 4] : instr[RT_LSB +: 4];

    // raw hazard against the instruction in ex
    assign stall = fd_valid && ex_wr &&
                   ((use_rs && (src1 != '0) && (src1 == ex_dst)) ||
                    (use_src2 && (src2 != '0) && (src2 == ex_dst)));

    //////////////////////////////////////////////////
    // register file, r0 reads zero
    //////////////////////////////////////////////////
    assign rs_val   = (src1 == '0) ? '0 :
                      (wb_en && wb_idx == src1) ? wb_data : regs[src1];
    assign src2_val = (src2 == '0) ? '0 :
                      (wb_en && wb_idx == src2) ? wb_data : regs[src2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (run_en && wb_en && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    //////////////////////////////////////////////////
    // pc and fetch
    //////////////////////////////////////////////////
    // refetch the held instruction when not advancing
    assign fetch_addr = (run_en && !stall) ? pc : pc_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            pc_d     <= '0;
            fd_valid <= 1'b0;
        end else if (run_en && !stall) begin
            pc_d     <= pc;
            pc       <= pc + 16'd4;
            fd_valid <= 1'b1;
        end
    end

    // bubble unless a legal instruction is ready to go
    always_comb begin
        issue = '0;
        if (fd_valid && !stall && legal) begin
            issue.op  = op;
            issue.a   = rs_val;
            issue.b   = src2_val;
            issue.imm = {{(32 - IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
            issue.dst = instr[RD_LSB +: 4];
        end
    end

endmodule

// File: core/exec_stage.sv
//////////////////////////////////////////////////
// exec_stage: decode/execute register, ALU, data
// memory access and writeback
//////////////////////////////////////////////////
`timescale 1ns/10ps

module exec_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run_en,
    input  issue_t     issue,
    input  word_t      dm_rd_data,
    output dm_access_t dm_access,
    output reg_idx_t   ex_dst,
    output logic       ex_wr,
    output logic       wb_en,
    output reg_idx_t   wb_idx,
    output word_t      wb_data
);

    issue_t   ex_q;
    word_t    op_b, alu;
    logic     wb_ld_q;
    word_t    wb_alu_q;

    // decode/execute register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_q <= '0;    // nop
        else if (run_en)
            ex_q <= issue;
    end

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    assign op_b = (ex_q.op inside {ADDI, LD, ST}) ? ex_q.imm : ex_q.b;

    always_comb begin
        case (ex_q.op)
            ADD, ADDI, LD, ST: alu = ex_q.a + op_b;    // ld/st address too
            SUB:               alu = ex_q.a - op_b;
            AND:               alu = ex_q.a & op_b;
            OR:                alu = ex_q.a | op_b;
            XOR:               alu = ex_q.a ^ op_b;
            default:           alu = '0;
        endcase
    end

    assign ex_wr  = ex_q.op inside {ADD, SUB, AND, OR, XOR, ADDI, LD};
    assign ex_dst = ex_q.dst;

    // data access during ex
    assign dm_access = '{rd_en: run_en && (ex_q.op == LD),
                         wr_en: run_en && (ex_q.op == ST),
                         addr:  alu[15:0],
                         data:  ex_q.b};

    //////////////////////////////////////////////////
    // writeback
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en   <= 1'b0;
            wb_ld_q <= 1'b0;
        end else if (run_en) begin
            wb_en   <= ex_wr;
            wb_ld_q <= (ex_q.op == LD);
        end
    end

    always_ff @(posedge clk) begin
        if (run_en) begin
            wb_idx   <= ex_q.dst;
            wb_alu_q <= alu;
        end
    end

    assign wb_data = wb_ld_q ? dm_rd_data : wb_alu_q;    // load data lands here

endmodule

// File: files.f
common/cpu_pkg.sv
rtl/host_ctrl.sv
rtl/instr_mem.sv
rtl/data_mem.sv
core/decode_stage.sv
core/exec_stage.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

// File: rtl/cpu_top.sv
//////////////////////////////////////////////////
// cpu_top: boot loader, memories and core
//////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
    parameter int BLOCK_WORDS = 16,
    parameter int DM_BLOCKS   = 4,
    parameter int IM_BLOCKS   = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ready,
    input  logic      rd_valid,
    input  logic      tx_done,
    input  word_t     rd_data,
    output host_req_t host_req
);

    localparam int DM_DEPTH = BLOCK_WORDS * DM_BLOCKS;
    localparam int IM_DEPTH = BLOCK_WORDS * IM_BLOCKS;

    mem_wr_t     im_wr, dm_wr;
    dm_access_t  dm_access;
    logic        run_en;
    logic [15:0] fetch_addr;
    word_t       instr, dm_rd_data, wb_data;
    logic        wb_en, ex_wr;
    reg_idx_t    wb_idx, ex_dst;
    issue_t      issue;

    host_ctrl #(
        .BLOCK_WORDS(BLOCK_WORDS),
        .DM_BLOCKS  (DM_BLOCKS),
        .IM_BLOCKS  (IM_BLOCKS)
    ) u_host_ctrl (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .rd_data(rd_data), .dm_access(dm_access), .host_req(host_req),
        .im_wr(im_wr), .dm_wr(dm_wr), .run_en(run_en)
    );

    instr_mem #(.DEPTH(IM_DEPTH)) u_instr_mem (
        .clk(clk), .wr(im_wr), .fetch_addr(fetch_addr), .instr(instr)
    );

    data_mem #(.DEPTH(DM_DEPTH)) u_data_mem (
        .clk(clk), .wr(dm_wr), .access(dm_access), .rd_data(dm_rd_data)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .run_en(run_en), .instr(instr), .fetch_addr(fetch_addr),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
        .ex_dst(ex_dst), .ex_wr(ex_wr), .issue(issue)
    );

    exec_stage u_exec (
        .clk(clk), .rst_n(rst_n), .run_en(run_en), .issue(issue), .dm_rd_data(dm_rd_data),
        .dm_access(dm_access), .ex_dst(ex_dst), .ex_wr(ex_wr),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
    );

endmodule

// File: rtl/data_mem.sv
//////////////////////////////////////////////////
// data_mem: data RAM written by the loader and
// by core stores below the host window
//////////////////////////////////////////////////
`timescale 1ns/10ps

module data_mem import cpu_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic       clk,
    input  mem_wr_t    wr,
    input  dm_access_t access,
    output word_t      rd_data
);

    localparam int AW = $clog2(DEPTH);

    word_t          mem [DEPTH];
    logic           local_hit;
    logic [AW-1:0]  core_idx;

    assign local_hit = (access.addr < HOST_WINDOW);
    assign core_idx  = access.addr[AW+1:2];    // drop byte offset

    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr[AW-1:0]] <= wr.data;
        else if (access.wr_en && local_hit)
            mem[core_idx] <= access.data;

        if (access.rd_en && local_hit)
            rd_data <= mem[core_idx];    // one cycle later in wb
    end

endmodule

// File: rtl/host_ctrl.sv
//////////////////////////////////////////////////
// host_ctrl: boot loading of both memories, run
// control and write-back of host-window stores
//////////////////////////////////////////////////
`timescale 1ns/10ps

module host_ctrl import cpu_pkg::*; #(
    parameter int BLOCK_WORDS = 16,
    parameter int DM_BLOCKS   = 4,
    parameter int IM_BLOCKS   = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ready,
    input  logic       rd_valid,
    input  logic       tx_done,
    input  word_t      rd_data,
    input  dm_access_t dm_access,
    output host_req_t  host_req,
    output mem_wr_t    im_wr,
    output mem_wr_t    dm_wr,
    output logic       run_en
);

    localparam logic [31:0] BLOCK_BYTES = 32'(BLOCK_WORDS * 4);

    ctrl_state_e state, state_nxt;
    logic [7:0]  blk_cnt, blk_nxt;
    logic [15:0] word_idx, word_nxt;
    logic [15:0] wr_addr_q;
    word_t       wr_data_q;
    logic        loading_dm, loading_im, last_blk, host_store;
    logic [31:0] blk_off;

    assign loading_dm = (state == REQ_DM) || (state == LOAD_DM);
    assign loading_im = (state == REQ_IM) || (state == LOAD_IM);
    assign last_blk   = loading_dm ? (blk_cnt == 8'(DM_BLOCKS - 1))
                                   : (blk_cnt == 8'(IM_BLOCKS - 1));
    assign blk_off    = 32'(blk_cnt) * BLOCK_BYTES;
    assign run_en     = (state == RUN);

    // store into the host window while running
    assign host_store = (state == RUN) && dm_access.wr_en && (dm_access.addr >= HOST_WINDOW);

    //////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CTRL_IDLE;
            blk_cnt  <= '0;
            word_idx <= '0;
        end else begin
            state    <= state_nxt;
            blk_cnt  <= blk_nxt;
            word_idx <= word_nxt;
        end
    end

    // captured store, held on the bus until tx_done
    always_ff @(posedge clk) begin
        if (host_store) begin
            wr_addr_q <= dm_access.addr;
            wr_data_q <= dm_access.data;
        end
    end

    always_comb begin
        state_nxt = state;
        blk_nxt   = blk_cnt;
        word_nxt  = word_idx;
        if (rd_valid && (loading_dm || loading_im))
            word_nxt = word_idx + 16'd1;    // next word slot

        case (state)
            CTRL_IDLE: begin
                if (ready) begin
                    state_nxt = REQ_DM;
                    blk_nxt   = '0;
                    word_nxt  = '0;
                end
            end
            REQ_DM, LOAD_DM, REQ_IM, LOAD_IM: begin
                if (tx_done) begin
                    if (last_blk) begin
                        // dm done -> start im, im done -> run
                        state_nxt = loading_dm ? REQ_IM : RUN;
                        blk_nxt   = '0;
                        word_nxt  = '0;
                    end else begin
                        state_nxt = loading_dm ? REQ_DM : REQ_IM;
                        blk_nxt   = blk_cnt + 8'd1;
                        word_nxt  = 16'(32'(blk_cnt + 8'd1) * BLOCK_WORDS);
                    end
                end else begin
                    state_nxt = loading_dm ? LOAD_DM : LOAD_IM;
                end
            end
            RUN: begin
                if (host_store)
                    state_nxt = WRT_HOST;
            end
            WRT_HOST: begin
                if (tx_done)
                    state_nxt = RUN;    // core resumes next cycle
            end
            default: state_nxt = CTRL_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // host bus and loader writes
    //////////////////////////////////////////////////
    always_comb begin
        host_req = '0;
        if (loading_dm) begin
            host_req.op   = READ;
            host_req.addr = DM_HOST_BASE + blk_off;
        end else if (loading_im) begin
            host_req.op   = READ;
            host_req.addr = IM_HOST_BASE + blk_off;
        end else if (state == WRT_HOST) begin
            host_req.op   = WRITE;
            host_req.addr = {16'h0, wr_addr_q};
            host_req.data = wr_data_q;
        end
    end

    assign dm_wr = '{en: loading_dm && rd_valid, addr: word_idx, data: rd_data};
    assign im_wr = '{en: loading_im && rd_valid, addr: word_idx, data: rd_data};

endmodule

// File: rtl/instr_mem.sv
//////////////////////////////////////////////////
// instr_mem: instruction RAM, loader write port
// and synchronous fetch read
//////////////////////////////////////////////////
`timescale 1ns/10ps

module instr_mem import cpu_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic        clk,
    input  mem_wr_t     wr,
    input  logic [15:0] fetch_addr,    // byte address
    output word_t       instr
);

    localparam int AW = $clog2(DEPTH);

    word_t mem [DEPTH];

    // loader wins over fetch
    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr[AW-1:0]] <= wr.data;
        else
            instr <= mem[fetch_addr[AW+1:2]];
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpu_tb \
    -f files.f --Mdir obj_dir -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

// File: verif/cpu_tb.sv
//////////////////////////////////////////////////
// cpu_tb drives the boot-loaded core through a host
// model and checks its host writes against a reference
//////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

    localparam int BLOCK_WORDS  = 16;
    localparam int DM_BLOCKS    = 4;
    localparam int IM_BLOCKS    = 4;
    localparam int DM_WORDS     = BLOCK_WORDS * DM_BLOCKS;
    localparam int IM_WORDS     = BLOCK_WORDS * IM_BLOCKS;
    localparam int READ_LIMIT   = 100;     // cycles to wait for each block request
    localparam int WRITE_LIMIT  = 3000;    // covers the whole boot for the first write
    localparam int QUIET_CYCLES = 20;

    logic      clk, rst_n, ready, rd_valid, tx_done;
    word_t     rd_data;
    host_req_t host_req;

    word_t       dm_image [DM_WORDS];
    word_t       im_image [IM_WORDS];
    logic [15:0] exp_addr [$];
    word_t       exp_data [$];
    integer      seed;
    int          errors, checks, n_writes, n_exp;
    host_op_e    prev_op;

    cpu_top #(
        .BLOCK_WORDS(BLOCK_WORDS),
        .DM_BLOCKS  (DM_BLOCKS),
        .IM_BLOCKS  (IM_BLOCKS)
    ) uut (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid),
        .tx_done(tx_done), .rd_data(rd_data), .host_req(host_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every new WRITE request on the bus
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_op  <= IDLE;
            n_writes <= 0;
        end else begin
            if (host_req.op == WRITE && prev_op != WRITE)
                n_writes <= n_writes + 1;
            prev_op <= host_req.op;
        end
    end

    //////////////////////////////////////////////////
    // program and data images
    //////////////////////////////////////////////////
    function automatic word_t enc_r(opcode_e op, int rd, int rs, int rt);
        return {op, 4'(rd), 4'(rs), 4'(rt), 12'h000};
    endfunction

    function automatic word_t enc_i(opcode_e op, int rd, int rs, int imm);
        return {op, 4'(rd), 4'(rs), 16'(imm)};
    endfunction

    function automatic void build_images();
        for (int i = 0; i < DM_WORDS; i++)
            dm_image[i] = 32'hd000_0000 + 32'(i) * 32'h0003_0107;
        for (int i = 0; i < IM_WORDS; i++)
            im_image[i] = '0;                        // nop padding
        im_image[0]  = enc_i(ADDI, 1, 0, 5);
        im_image[1]  = enc_i(ADDI, 2, 0, -3);
        im_image[2]  = enc_r(ADD, 3, 1, 2);          // back-to-back dependency
        im_image[3]  = enc_r(SUB, 4, 3, 1);
        im_image[4]  = enc_r(AND, 5, 4, 2);
        im_image[5]  = enc_r(OR, 6, 5, 1);
        im_image[6]  = enc_r(XOR, 7, 6, 2);
        im_image[7]  = enc_i(ADDI, 8, 0, 'h9000);    // host window pointer
        im_image[8]  = enc_i(ST, 3, 8, 0);
        im_image[9]  = enc_i(ST, 7, 8, 4);
        im_image[10] = enc_i(LD, 9, 0, 'h20);        // preloaded word
        im_image[11] = enc_r(ADD, 10, 9, 1);         // load-use hazard
        im_image[12] = enc_i(ST, 10, 8, 8);
        im_image[13] = enc_i(ST, 6, 0, 'h40);        // local store
        im_image[14] = enc_i(LD, 11, 0, 'h40);       // reads it back
        im_image[15] = enc_r(XOR, 12, 11, 4);
        im_image[16] = enc_i(ST, 12, 8, 'hc);
        im_image[17] = enc_i(LD, 13, 0, 'hc4);       // word from the last dm block
        im_image[18] = enc_r(SUB, 14, 13, 12);
        im_image[19] = enc_i(ST, 14, 8, 'h10);
        im_image[20] = enc_i(ADDI, 15, 8, 'h100);
        im_image[21] = enc_i(ST, 5, 15, 0);
        im_image[22] = enc_i(NOP, 0, 0, 0);
        im_image[23] = enc_i(ST, 0, 8, 'h14);        // r0 as store data
        im_image[24] = enc_i(ST, 1, 15, -4);         // two host stores in a row
        im_image[25] = enc_i(ADDI, 0, 1, 7);         // write to r0 is dropped
        im_image[26] = enc_i(ST, 0, 8, 'h18);
    endfunction

    //////////////////////////////////////////////////
    // reference model over one pass of the program
    //////////////////////////////////////////////////
    function automatic int ref_run();
        word_t       regs [16];
        word_t       mem [DM_WORDS];
        word_t       ins, a, b, imm;
        logic [15:0] addr;
        opcode_e     op;
        reg_idx_t    rd, rs, rt;
        int          n;
        n = 0;
        for (int i = 0; i < 16; i++)
            regs[i] = '0;
        for (int i = 0; i < DM_WORDS; i++)
            mem[i] = dm_image[i];
        exp_addr.delete();
        exp_data.delete();
        for (int pc = 0; pc < IM_WORDS; pc++) begin
            ins  = im_image[pc];
            op   = opcode_e'(ins[31:24]);
            rd   = ins[23:20];
            rs   = ins[19:16];
            rt   = ins[15:12];
            imm  = {{16{ins[15]}}, ins[15:0]};
            a    = regs[rs];
            b    = regs[rt];
            addr = 16'(a + imm);
            case (op)
                ADD:  regs[rd] = a + b;
                SUB:  regs[rd] = a - b;
                AND:  regs[rd] = a & b;
                OR:   regs[rd] = a | b;
                XOR:  regs[rd] = a ^ b;
                ADDI: regs[rd] = a + imm;
                LD:   regs[rd] = mem[int'(addr >> 2) % DM_WORDS];
                ST: begin
                    if (addr >= HOST_WINDOW) begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(regs[rd]);
                        n++;
                    end else begin
                        mem[int'(addr >> 2) % DM_WORDS] = regs[rd];
                    end
                end
                default: ;
            endcase
            regs[0] = '0;    // r0 stays zero
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic check32(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_op(string name, host_op_e exp);
        checks++;
        if (host_req.op !== exp) begin
            errors++;
            $display("Fail %s: expected op %0d, actual op %0d", name, exp, host_req.op);
        end
    endtask

    task automatic check_read_held(logic [31:0] addr);
        check_op("read_hold_op", READ);
        check32("read_hold_addr", addr, host_req.addr);
    endtask

    task automatic check_write_held(logic [31:0] addr, word_t data);
        check_op("write_hold_op", WRITE);
        check32("write_hold_addr", addr, host_req.addr);
        check32("write_hold_data", data, host_req.data);
    endtask

    //////////////////////////////////////////////////
    // host model for block reads
    //////////////////////////////////////////////////
    task automatic serve_reads();
        logic [31:0] blk_addr, want_addr;
        int          base_idx, gap, waited;
        bit          is_im;
        for (int blk = 0; blk < DM_BLOCKS + IM_BLOCKS; blk++) begin
            is_im     = (blk >= DM_BLOCKS);
            base_idx  = is_im ? (blk - DM_BLOCKS) * BLOCK_WORDS : blk * BLOCK_WORDS;
            want_addr = (is_im ? IM_HOST_BASE : DM_HOST_BASE) + 32'(base_idx * 4);
            waited    = 0;
            @(posedge clk);
            while (host_req.op != READ && waited < READ_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (host_req.op != READ) begin
                errors++;
                $display("Timeout: no READ request arrived for block %0d", blk);
                break;
            end
            blk_addr = host_req.addr;
            check32("read_addr", want_addr, blk_addr);
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) begin
                    rd_valid <= 1'b0;
                    tx_done  <= 1'b0;
                    @(posedge clk);
                    check_read_held(blk_addr);
                end
                rd_valid <= 1'b1;
                rd_data  <= is_im ? im_image[base_idx + w] : dm_image[base_idx + w];
                tx_done  <= (w == BLOCK_WORDS - 1);    // ends with the last word
                @(posedge clk);
                check_read_held(blk_addr);
            end
            rd_valid <= 1'b0;
            tx_done  <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // host model for write-back compare
    //////////////////////////////////////////////////
    task automatic compare_writes(int count);
        logic [31:0] addr0;
        word_t       data0;
        int          waited, hold;
        for (int k = 0; k < count; k++) begin
            waited = 0;
            @(posedge clk);
            while (host_req.op != WRITE && waited < WRITE_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (host_req.op != WRITE) begin
                errors++;
                $display("Timeout: host write %0d of %0d never arrived", k + 1, count);
                break;
            end
            addr0 = host_req.addr;
            data0 = host_req.data;
            check32("write_addr", {16'h0, exp_addr[k]}, addr0);
            check32("write_data", exp_data[k], data0);
            hold = $unsigned($random(seed)) % 4;    // back-pressure
            repeat (hold) begin
                @(posedge clk);
                check_write_held(addr0, data0);
            end
            tx_done <= 1'b1;
            @(posedge clk);
            check_write_held(addr0, data0);
            tx_done <= 1'b0;
        end
    endtask

    initial begin
        seed     = 83811;
        errors   = 0;
        checks   = 0;
        rst_n    = 1'b0;
        ready    = 1'b0;
        rd_valid = 1'b0;
        tx_done  = 1'b0;
        rd_data  = '0;
        build_images();
        n_exp = ref_run();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_op("idle_before_ready", IDLE);
        end
        ready <= 1'b1;

        fork
            serve_reads();
            compare_writes(n_exp);
        join

        // nothing more may reach the bus
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            check_op("no_extra_request", IDLE);
        end
        check32("write_count", 32'(n_exp), 32'(n_writes));

        $display("checks: %0d  errors: %0d  host writes: %0d of %0d",
                 checks, errors, n_writes, n_exp);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
